/* src/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath and register width
`define RV_XLEN 32

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_ADDR_W 5

// fetch starts here after reset
`define RV_RESET_PC 32'h0000_0000
`define RV_INSN_STEP 4

`endif

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

  // major opcodes, low two bits always 11
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b000_0011,
    OPC_STORE  = 7'b010_0011,
    OPC_BRANCH = 7'b110_0011,
    OPC_JALR   = 7'b110_0111,
    OPC_JAL    = 7'b110_1111,
    OPC_OP_IMM = 7'b001_0011,
    OPC_OP     = 7'b011_0011,
    OPC_SYSTEM = 7'b111_0011,
    OPC_AUIPC  = 7'b001_0111,
    OPC_LUI    = 7'b011_0111
  } opcode_e;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // alu sub-operations, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // only word-wide memory access
  localparam logic [2:0] F3_LW = 3'b010;
  localparam logic [2:0] F3_SW = 3'b010;

  // alt encoding selects sub and sra
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  // R-type field layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } insn_t;

endpackage

/* src/rv_core_pkg.sv */
`include "rv_cfg.svh"

package rv_core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRANCH,
    PC_JAL,
    PC_JALR
  } pc_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK
  } wb_sel_e;

  // one control word per instruction
  typedef struct packed {
    logic                      reg_we;
    logic [`RV_REG_ADDR_W-1:0] rd;
    alu_op_e                   alu_op;
    logic                      a_pc;
    logic                      b_imm;
    logic [`RV_XLEN-1:0]       imm;
    pc_sel_e                   pc_sel;
    wb_sel_e                   wb_sel;
    logic [2:0]                br_funct3;
    logic                      store;
    logic                      halt;
  } ctrl_t;

  // data port request, we is per byte
  typedef struct packed {
    logic [`RV_XLEN-1:0]   addr;
    logic [`RV_XLEN-1:0]   wdata;
    logic [`RV_XLEN/8-1:0] we;
  } dmem_req_t;

endpackage

/* src/rv_decoder.sv */
`timescale 1ns/10ps

`include "rv_cfg.svh"

module rv_decoder (
  input  rv_isa_pkg::insn_t  insn,
  output rv_core_pkg::ctrl_t ctrl
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [31:0]         raw;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_u;
  logic                op_ok;
  logic                imm_ok;

  // funct3 plus alt bit to alu operation
  function automatic alu_op_e alu_op_of(input logic [2:0] funct3, input logic alt);
    alu_op_e op;
    case (funct3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  assign raw = insn;

  // immediates, sign bit is always insn[31]
  assign imm_i = {{(`RV_XLEN-12){raw[31]}}, raw[31:20]};
  assign imm_s = {{(`RV_XLEN-12){raw[31]}}, raw[31:25], raw[11:7]};
  assign imm_b = {{(`RV_XLEN-13){raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
  assign imm_u = {raw[31:12], 12'b0};

  // register-register: only sub and sra use the alt funct7
  assign op_ok = (insn.funct7 == F7_BASE) ||
                 ((insn.funct7 == F7_ALT) && (insn.funct3 == F3_ADD || insn.funct3 == F3_SR));

  // shifts by immediate carry funct7 in the upper immediate bits
  always_comb begin
    if (insn.funct3 == F3_SLL) begin
      imm_ok = (insn.funct7 == F7_BASE);
    end else if (insn.funct3 == F3_SR) begin
      imm_ok = (insn.funct7 == F7_BASE) || (insn.funct7 == F7_ALT);
    end else begin
      imm_ok = 1'b1;
    end
  end

  always_comb begin
    // no write, sequential pc unless an opcode below says otherwise
    ctrl           = '0;
    ctrl.rd        = insn.rd;
    ctrl.alu_op    = ALU_ADD;
    ctrl.imm       = imm_i;
    ctrl.pc_sel    = PC_SEQ;
    ctrl.wb_sel    = WB_ALU;
    ctrl.br_funct3 = insn.funct3;
    case (insn.opcode)
      OPC_LUI: begin
        ctrl.reg_we = 1'b1;
        ctrl.alu_op = ALU_PASS_B;
        ctrl.b_imm  = 1'b1;
        ctrl.imm    = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.reg_we = 1'b1;
        ctrl.a_pc   = 1'b1;
        ctrl.b_imm  = 1'b1;
        ctrl.imm    = imm_u;
      end
      OPC_OP_IMM: begin
        ctrl.reg_we = imm_ok;
        ctrl.alu_op = alu_op_of(insn.funct3, insn.funct3 == F3_SR && insn.funct7 == F7_ALT);
        ctrl.b_imm  = 1'b1;
      end
      OPC_OP: begin
        ctrl.reg_we = op_ok;
        ctrl.alu_op = alu_op_of(insn.funct3, insn.funct7 == F7_ALT);
      end
      OPC_BRANCH: begin
        ctrl.imm = imm_b;
        case (insn.funct3)
          F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: ctrl.pc_sel = PC_BRANCH;
          default: ctrl.pc_sel = PC_SEQ;
        endcase
      end
      OPC_JAL: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = WB_LINK;
        ctrl.pc_sel = PC_JAL;
        ctrl.imm    = imm_j;
      end
      OPC_JALR: begin
        if (insn.funct3 == 3'b000) begin
          // alu computes rs1 + imm as the target
          ctrl.reg_we = 1'b1;
          ctrl.wb_sel = WB_LINK;
          ctrl.pc_sel = PC_JALR;
          ctrl.b_imm  = 1'b1;
        end
      end
      OPC_LOAD: begin
        ctrl.reg_we = (insn.funct3 == F3_LW);
        ctrl.wb_sel = WB_LOAD;
        ctrl.b_imm  = 1'b1;
      end
      OPC_STORE: begin
        ctrl.store = (insn.funct3 == F3_SW);
        ctrl.b_imm = 1'b1;
        ctrl.imm   = imm_s;
      end
      OPC_SYSTEM: begin
        // ecall only, everything above the opcode is zero
        ctrl.halt = (raw[31:7] == 25'd0);
      end
      default: begin
        ctrl.reg_we = 1'b0;
      end
    endcase
  end

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/10ps

`include "rv_cfg.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  input  logic [`RV_REG_ADDR_W-1:0] rd,
  input  logic                      we,
  input  logic [`RV_XLEN-1:0]       rd_data,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // x0 reads as zero whatever the array holds
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

/* src/rv_alu.sv */
`timescale 1ns/10ps

`include "rv_cfg.svh"

module rv_alu (
  input  rv_core_pkg::alu_op_e op,
  input  logic [`RV_XLEN-1:0]  a,
  input  logic [`RV_XLEN-1:0]  b,
  output logic [`RV_XLEN-1:0]  result
);
  import rv_core_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shifts use only the low five bits
  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      // lui, immediate straight through
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

endmodule

/* src/rv_pc_unit.sv */
`timescale 1ns/10ps

`include "rv_cfg.svh"

module rv_pc_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hold,
  input  rv_core_pkg::pc_sel_e pc_sel,
  input  logic [2:0]           br_funct3,
  input  logic [`RV_XLEN-1:0]  rs1_data,
  input  logic [`RV_XLEN-1:0]  rs2_data,
  input  logic [`RV_XLEN-1:0]  imm,
  input  logic [`RV_XLEN-1:0]  jalr_target,
  output logic [`RV_XLEN-1:0]  pc,
  output logic [`RV_XLEN-1:0]  pc_plus4
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam logic [`RV_XLEN-1:0] RESET_PC  = `RV_RESET_PC;
  localparam logic [`RV_XLEN-1:0] INSN_STEP = `RV_INSN_STEP;

  logic [`RV_XLEN-1:0] pc_rel;
  logic [`RV_XLEN-1:0] pc_next;
  logic                taken;

  assign pc_plus4 = pc + INSN_STEP;
  // branch and jal share the pc-relative adder
  assign pc_rel   = pc + imm;

  always_comb begin
    case (br_funct3)
      F3_BEQ:  taken = (rs1_data == rs2_data);
      F3_BNE:  taken = (rs1_data != rs2_data);
      F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: taken = (rs1_data < rs2_data);
      F3_BGEU: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (pc_sel)
      PC_BRANCH: pc_next = taken ? pc_rel : pc_plus4;
      PC_JAL:    pc_next = pc_rel;
      // jalr clears bit 0 of the target
      PC_JALR:   pc_next = {jalr_target[`RV_XLEN-1:1], 1'b0};
      default:   pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (!hold) begin
      pc <= pc_next;
    end
  end

endmodule

/* src/rv_core.sv */
`timescale 1ns/10ps

`include "rv_cfg.svh"

module rv_core (
  input  logic                   clk,
  input  logic                   rst,
  output logic [`RV_XLEN-1:0]    pc,
  input  rv_isa_pkg::insn_t      insn,
  output rv_core_pkg::dmem_req_t dmem_req,
  input  logic [`RV_XLEN-1:0]    dmem_rdata,
  output logic                   halt
);
  import rv_core_pkg::*;

  ctrl_t               ctrl;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] wb_data;
  logic                reg_we;
  logic                store_en;

  rv_decoder decoder_i (
    .insn (insn),
    .ctrl (ctrl)
  );

  // nothing commits during reset or on the halting instruction
  assign halt     = ctrl.halt & ~rst;
  assign reg_we   = ctrl.reg_we & ~rst & ~ctrl.halt;
  assign store_en = ctrl.store & ~rst & ~ctrl.halt;

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (insn.rs1),
    .rs2      (insn.rs2),
    .rd       (ctrl.rd),
    .we       (reg_we),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = ctrl.a_pc ? pc : rs1_data;
  assign alu_b = ctrl.b_imm ? ctrl.imm : rs2_data;

  rv_alu alu_i (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_pc_unit pc_unit_i (
    .clk         (clk),
    .rst         (rst),
    .hold        (halt),
    .pc_sel      (ctrl.pc_sel),
    .br_funct3   (ctrl.br_funct3),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (ctrl.imm),
    .jalr_target (alu_result),
    .pc          (pc),
    .pc_plus4    (pc_plus4)
  );

  always_comb begin
    case (ctrl.wb_sel)
      WB_LOAD: wb_data = dmem_rdata;
      WB_LINK: wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  // alu result is the effective address for lw and sw
  assign dmem_req.addr  = alu_result;
  assign dmem_req.wdata = rs2_data;
  assign dmem_req.we    = {(`RV_XLEN/8){store_en}};

endmodule

/* bench/rv_core_programs.svh */
`ifndef RV_CORE_PROGRAMS_SVH
`define RV_CORE_PROGRAMS_SVH

// instruction encoders, one per format
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

task automatic emit(input logic [31:0] word);
  imem[prog_len] = word;
  prog_len++;
endtask

// lui + addi, upper part corrected for the sign of the low 12 bits
task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
  logic [31:0] lo;
  logic [31:0] hi;
  lo = {{20{value[11]}}, value[11:0]};
  hi = value - lo;
  emit(enc_u(hi[31:12], rd, OPC_LUI));
  emit(enc_i(value[11:0], rd, F3_ADD, rd, OPC_OP_IMM));
endtask

// sw to the next result slot, remembered with its expected word
task automatic store_expect(input logic [4:0] rs, input logic [31:0] value);
  logic [31:0] addr;
  addr = STORE_BASE + slot * 4;
  emit(enc_s(addr[11:0], rs, 5'd0));
  exp_mem[addr] = value;
  slot++;
endtask

// x3 holds the poison word
task automatic skip_poison();
  emit(enc_s(POISON_ADDR[11:0], 5'd3, 5'd0));
endtask

`endif

/* bench/rv_core_tb.sv */
`timescale 1ns/10ps

`include "rv_cfg.svh"

module rv_core_tb;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam int          IMEM_WORDS  = 512;
  localparam int          DMEM_WORDS  = 512;
  localparam logic [31:0] STORE_BASE  = 32'h0000_0400;
  localparam logic [31:0] POISON      = 32'hdead_beef;
  localparam logic [31:0] POISON_ADDR = 32'h0000_07fc;
  localparam logic [31:0] LOAD_ADDR   = 32'h0000_0100;
  localparam logic [31:0] LFSR_SEED   = 32'h4db7_b27c;

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] pc;
  insn_t               insn;
  dmem_req_t           dmem_req;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic                halt;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  logic [31:0] exp_mem [logic [31:0]];
  bit          store_seen [logic [31:0]];
  logic [31:0] jump_tgt [logic [31:0]];
  int          prog_len;
  int          slot;
  int          cycles;
  int          limit;
  logic [31:0] lfsr_state;
  logic        prev_rst;
  logic        halt_prev;
  logic [31:0] halt_pc;
  logic [31:0] last_pc;
  logic        last_valid;

  rv_core rv_core_i (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .insn       (insn),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  // both memories answer in the same cycle
  assign insn       = imem[pc[10:2]];
  assign dmem_rdata = dmem[dmem_req.addr[10:2]];

  always #50 clk = ~clk;

  task automatic value_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
    $display("SOME TESTS FAILED");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic run_failure(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "%s", what);
  endtask

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // RV32I integer results
  function automatic logic [31:0] op_rule(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      F3_ADD:  return alt ? a - b : a + b;
      F3_SLL:  return a << b[4:0];
      F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
      F3_SLTU: return {31'b0, a < b};
      F3_XOR:  return a ^ b;
      F3_SR:   return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  `include "rv_core_programs.svh"

  task automatic alu_imm_test(input logic [2:0] f3, input logic alt);
    logic [31:0] a;
    logic [11:0] imm;
    a = rand_bits(32);
    if (f3 == F3_SLL || f3 == F3_SR) begin
      imm = {alt ? F7_ALT : F7_BASE, 5'(rand_bits(5))};
    end else begin
      imm = 12'(rand_bits(12));
    end
    load_const(5'd1, a);
    emit(enc_i(imm, 5'd1, f3, 5'd4, OPC_OP_IMM));
    store_expect(5'd4, op_rule(f3, alt, a, {{20{imm[11]}}, imm}));
  endtask

  task automatic alu_reg_test(input logic [2:0] f3, input logic alt);
    logic [31:0] a;
    logic [31:0] b;
    a = rand_bits(32);
    b = rand_bits(32);
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit(enc_r(alt ? F7_ALT : F7_BASE, 5'd2, 5'd1, f3, 5'd4));
    store_expect(5'd4, op_rule(f3, alt, a, b));
  endtask

  // taken skips the poison sw, not taken jumps over it
  task automatic branch_test(input logic [2:0] f3, input logic want);
    logic [31:0] a;
    logic [31:0] b;
    a = rand_bits(32);
    b = rand_bits(32);
    if (b == a) begin
      b = ~a;
    end
    if (branch_rule(f3, a, a) == want) begin
      b = a;
    end else if (branch_rule(f3, b, a) == want) begin
      {a, b} = {b, a};
    end
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit(enc_b(13'd8, 5'd2, 5'd1, f3));
    if (!want) begin
      emit(enc_j(21'd8, 5'd0));
    end
    skip_poison();
  endtask

  task automatic jump_tests();
    logic [31:0] p;
    p = prog_len * 4;
    emit(enc_j(21'd8, 5'd7));
    jump_tgt[p] = p + 8;
    skip_poison();
    store_expect(5'd7, p + 4);
    // jalr to p+13, bit 0 dropped
    p = prog_len * 4;
    emit(enc_i(12'(p + 12), 5'd0, F3_ADD, 5'd8, OPC_OP_IMM));
    emit(enc_i(12'd1, 5'd8, 3'b000, 5'd9, OPC_JALR));
    jump_tgt[p + 4] = p + 12;
    skip_poison();
    store_expect(5'd9, p + 8);
  endtask

  task automatic build_program();
    logic [19:0] u;
    logic [31:0] p;
    logic [31:0] w;
    logic [2:0]  br_f3 [6];
    br_f3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    // a store sits at the reset pc while rst is still high
    store_expect(5'd0, 32'd0);
    load_const(5'd3, POISON);
    for (int f = 0; f < 8; f++) begin
      alu_imm_test(3'(f), 1'b0);
      alu_reg_test(3'(f), 1'b0);
    end
    alu_imm_test(F3_SR, 1'b1);
    alu_reg_test(F3_SR, 1'b1);
    alu_reg_test(F3_ADD, 1'b1);
    u = 20'(rand_bits(20));
    emit(enc_u(u, 5'd5, OPC_LUI));
    store_expect(5'd5, {u, 12'b0});
    u = 20'(rand_bits(20));
    p = prog_len * 4;
    emit(enc_u(u, 5'd6, OPC_AUIPC));
    store_expect(5'd6, p + {u, 12'b0});
    emit(enc_i(12'h123, 5'd1, F3_ADD, 5'd0, OPC_OP_IMM));
    store_expect(5'd0, 32'd0);
    foreach (br_f3[i]) begin
      branch_test(br_f3[i], 1'b1);
      branch_test(br_f3[i], 1'b0);
    end
    jump_tests();
    w = rand_bits(32);
    dmem[LOAD_ADDR[10:2]] = w;
    emit(enc_i(LOAD_ADDR[11:0], 5'd0, F3_LW, 5'd10, OPC_LOAD));
    store_expect(5'd10, w);
    // ecall
    emit(32'h0000_0073);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      assert (dmem_req.we == '0) else value_mismatch("dmem_req.we", 32'd0, 32'(dmem_req.we));
      assert (!halt) else value_mismatch("halt", 32'd0, 32'(halt));
    end else begin
      if (prev_rst) begin
        assert (pc == 32'h0000_0000) else value_mismatch("pc", 32'h0000_0000, pc);
      end
      if (last_valid && jump_tgt.exists(last_pc)) begin
        assert (pc == jump_tgt[last_pc]) else value_mismatch("pc", jump_tgt[last_pc], pc);
      end
      if (halt_prev) begin
        assert (pc == halt_pc) else value_mismatch("pc", halt_pc, pc);
      end
      assert (!(halt && dmem_req.we != '0)) else run_failure("store issued while halt is high");
      if (dmem_req.we != '0) begin
        assert (dmem_req.wdata != POISON)
          else run_failure("store from an instruction that should have been skipped");
        if (exp_mem.exists(dmem_req.addr)) begin
          assert (dmem_req.wdata == exp_mem[dmem_req.addr])
            else value_mismatch("dmem_req.wdata", exp_mem[dmem_req.addr], dmem_req.wdata);
          store_seen[dmem_req.addr] = 1'b1;
        end else begin
          run_failure($sformatf("store to unexpected address %h", dmem_req.addr));
        end
        dmem[dmem_req.addr[10:2]] <= dmem_req.wdata;
      end
    end
    prev_rst   <= rst;
    halt_prev  <= halt;
    halt_pc    <= pc;
    last_pc    <= pc;
    last_valid <= !rst;
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    prev_rst   = 1'b0;
    halt_prev  = 1'b0;
    halt_pc    = '0;
    last_pc    = '0;
    last_valid = 1'b0;
    lfsr_state = LFSR_SEED;
    prog_len   = 0;
    slot       = 0;
    cycles     = 0;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'h5a00_0000 ^ (i * 4);
    end
    build_program();
    limit = 4 * prog_len + 20;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // halt is sampled mid-cycle where it is stable
    @(negedge clk);
    while (!halt && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      run_failure($sformatf("timeout: no ECALL reached within %0d cycles", limit));
    end else begin
      repeat (2) @(negedge clk);
      foreach (exp_mem[a]) begin
        if (!store_seen.exists(a)) begin
          run_failure($sformatf("expected store to address %h never happened", a));
        end
      end
      // reset while the ecall is still decoded
      @(posedge clk);
      rst <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

/* rv_core.f */
+incdir+src
+incdir+bench
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_pc_unit.sv
src/rv_core.sv
bench/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
RTL_TOP   ?= rv_core
FLIST     ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing -Wall

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(wildcard src/*.sv src/*.svh bench/*.sv bench/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
